//--- common/mc_link_pkg.sv
/*
 Wiring of one mesh link between the tile and the network.
 In each channel, v and data travel one way and ready travels back
 for the channel of the same name going the other way.
*/
package mc_link_pkg;

   import mc_packet_pkg::*;

   // forward channel carries requests
   typedef struct packed {
      logic        v;
      mc_req_pkt_s data;
      logic        ready;
   } mc_fwd_link_s;

   // reverse channel carries responses
   typedef struct packed {
      logic        v;
      mc_rsp_pkt_s data;
      logic        ready;
   } mc_rev_link_s;

   // one direction of a full link
   typedef struct packed {
      mc_fwd_link_s fwd;
      mc_rev_link_s rev;
   } mc_link_sif_s;

endpackage

//--- common/mc_packet_pkg.sv
/*
 Packet contents carried on the mesh link.
 Requests are loads or stores only. There are no byte masks or atomics.
 A response is addressed back to the src coordinates of its request.
*/
`include "mc_tile_defines.svh"

package mc_packet_pkg;

   // request opcode
   typedef enum logic {
      MC_OP_LOAD  = 1'b0,
      MC_OP_STORE = 1'b1
   } mc_op_e;

   // response kind
   typedef enum logic {
      MC_RSP_LOAD_DATA = 1'b0,
      MC_RSP_STORE_ACK = 1'b1
   } mc_rsp_type_e;

   // request packet on the forward channel
   typedef struct packed {
      mc_op_e                        op;
      logic [`MC_ADDR_WIDTH-1:0]     addr;
      logic [`MC_DATA_WIDTH-1:0]     data;
      logic [`MC_REG_ID_WIDTH-1:0]   reg_id;
      logic [`MC_X_CORD_WIDTH-1:0]   src_x;
      logic [`MC_Y_CORD_WIDTH-1:0]   src_y;
      logic [`MC_X_CORD_WIDTH-1:0]   dst_x;
      logic [`MC_Y_CORD_WIDTH-1:0]   dst_y;
   } mc_req_pkt_s;

   // response packet on the reverse channel
   // data is zero for a store ack
   typedef struct packed {
      mc_rsp_type_e                  rsp_type;
      logic [`MC_DATA_WIDTH-1:0]     data;
      logic [`MC_REG_ID_WIDTH-1:0]   reg_id;
      logic [`MC_X_CORD_WIDTH-1:0]   dst_x;
      logic [`MC_Y_CORD_WIDTH-1:0]   dst_y;
   } mc_rsp_pkt_s;

endpackage

//--- common/mc_tile_defines.svh
/*
 Widths and sizes shared by the tile RTL and its testbench.
 The data memory is indexed by the low address bits only.
 MC_CREDIT_WIDTH must be wide enough to hold MC_MAX_OUT_CREDITS.
*/
`ifndef MC_TILE_DEFINES_SVH
`define MC_TILE_DEFINES_SVH

// packet field widths
`define MC_ADDR_WIDTH      16
`define MC_DATA_WIDTH      32
`define MC_X_CORD_WIDTH    4
`define MC_Y_CORD_WIDTH    3
`define MC_REG_ID_WIDTH    5

// tile resources
`define MC_DMEM_WORDS      256
`define MC_MAX_OUT_CREDITS 8
`define MC_CREDIT_WIDTH    4
`define MC_FIFO_ELS        2

`endif

//--- hw/endpoint/mc_endpoint.sv
/*
 Endpoint between the mesh link and the tile.
 Every incoming request is assumed to be addressed to this tile.
 Outgoing commands get this tile's coordinates as their source.
 At most MC_MAX_OUT_CREDITS commands may wait for a returned response.
*/
`timescale 1ns/1ps
`include "mc_tile_defines.svh"

module mc_endpoint
   import mc_packet_pkg::*, mc_link_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic [`MC_X_CORD_WIDTH-1:0] my_x_i,
   input  logic [`MC_Y_CORD_WIDTH-1:0] my_y_i,

   input  mc_link_sif_s                link_sif_i,
   output mc_link_sif_s                link_sif_o,

   input  logic                        cmd_v_i,
   input  mc_req_pkt_s                 cmd_i,
   output logic                        cmd_ready_o,

   output logic                        returned_v_o,
   output mc_rsp_pkt_s                 returned_o,
   input  logic                        returned_ready_i,
   output logic [`MC_CREDIT_WIDTH-1:0] out_credits_o,

   output logic                        req_v_o,
   output mc_req_pkt_s                 req_o,
   input  logic                        req_yumi_i,

   input  logic                        rsp_v_i,
   input  mc_rsp_pkt_s                 rsp_i,
   output logic                        rsp_ready_o
);

   localparam logic [`MC_CREDIT_WIDTH-1:0] max_credits_lp = `MC_MAX_OUT_CREDITS;

   logic        in_req_ready;
   logic        out_req_ready;
   logic        out_req_v;
   mc_req_pkt_s out_req_pkt;
   logic        out_rsp_v;
   mc_rsp_pkt_s out_rsp_pkt;
   logic        ret_ready;
   mc_req_pkt_s cmd_stamped;
   logic        cmd_yumi;
   logic        returned_yumi;
   logic [`MC_CREDIT_WIDTH-1:0] credits_r;

   // source coordinates always come from this tile
   always_comb begin
      cmd_stamped       = cmd_i;
      cmd_stamped.src_x = my_x_i;
      cmd_stamped.src_y = my_y_i;
   end

   assign cmd_ready_o   = out_req_ready & (credits_r != '0);
   assign cmd_yumi      = cmd_v_i & cmd_ready_o;
   assign returned_yumi = returned_v_o & returned_ready_i;
   assign out_credits_o = credits_r;

   mc_fifo #(.payload_t(mc_req_pkt_s), .els_p(`MC_FIFO_ELS)) in_req_fifo (
      .clk_i, .arst_n_i,
      .v_i(link_sif_i.fwd.v & in_req_ready), .data_i(link_sif_i.fwd.data),
      .ready_o(in_req_ready),
      .v_o(req_v_o), .data_o(req_o), .yumi_i(req_yumi_i)
   );

   mc_fifo #(.payload_t(mc_rsp_pkt_s), .els_p(`MC_FIFO_ELS)) out_rsp_fifo (
      .clk_i, .arst_n_i,
      .v_i(rsp_v_i & rsp_ready_o), .data_i(rsp_i), .ready_o(rsp_ready_o),
      .v_o(out_rsp_v), .data_o(out_rsp_pkt),
      .yumi_i(out_rsp_v & link_sif_i.rev.ready)
   );

   mc_fifo #(.payload_t(mc_req_pkt_s), .els_p(`MC_FIFO_ELS)) out_req_fifo (
      .clk_i, .arst_n_i,
      .v_i(cmd_yumi), .data_i(cmd_stamped), .ready_o(out_req_ready),
      .v_o(out_req_v), .data_o(out_req_pkt),
      .yumi_i(out_req_v & link_sif_i.fwd.ready)
   );

   mc_fifo #(.payload_t(mc_rsp_pkt_s), .els_p(`MC_FIFO_ELS)) ret_rsp_fifo (
      .clk_i, .arst_n_i,
      .v_i(link_sif_i.rev.v & ret_ready), .data_i(link_sif_i.rev.data),
      .ready_o(ret_ready),
      .v_o(returned_v_o), .data_o(returned_o), .yumi_i(returned_yumi)
   );

   always_comb begin
      link_sif_o.fwd.v     = out_req_v;
      link_sif_o.fwd.data  = out_req_pkt;
      link_sif_o.fwd.ready = in_req_ready;
      link_sif_o.rev.v     = out_rsp_v;
      link_sif_o.rev.data  = out_rsp_pkt;
      link_sif_o.rev.ready = ret_ready;
   end

   // one credit per command in flight
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credits_r <= max_credits_lp;
      end else if (cmd_yumi && !returned_yumi) begin
         credits_r <= credits_r - 1'b1;
      end else if (returned_yumi && !cmd_yumi) begin
         credits_r <= credits_r + 1'b1;
      end
   end

   // no routing here, so the network must deliver only our own requests
   dst_is_me_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (link_sif_i.fwd.v && in_req_ready) |->
      (link_sif_i.fwd.data.dst_x == my_x_i && link_sif_i.fwd.data.dst_y == my_y_i));

   // more returns than commands would push this past the limit
   credit_limit_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      credits_r <= max_credits_lp);

endmodule

//--- hw/endpoint/mc_fifo.sv
/*
 Small synchronous FIFO with a ready-then-valid input.
 v_i may only be raised while ready_o is high.
 yumi_i pops the head and may only be raised while v_o is high.
 Storage has no reset. Only the pointers and the count are cleared.
*/
`timescale 1ns/1ps

module mc_fifo #(
   parameter type payload_t = logic,
   parameter int  els_p     = 2
) (
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     v_i,
   input  payload_t data_i,
   output logic     ready_o,
   output logic     v_o,
   output payload_t data_o,
   input  logic     yumi_i
);

   localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int cnt_w_lp = $clog2(els_p + 1);
   localparam logic [ptr_w_lp-1:0] last_ptr_lp = ptr_w_lp'(els_p - 1);
   localparam logic [cnt_w_lp-1:0] full_cnt_lp = cnt_w_lp'(els_p);

   payload_t            mem_r [els_p];
   logic [ptr_w_lp-1:0] wptr_r;
   logic [ptr_w_lp-1:0] rptr_r;
   logic [cnt_w_lp-1:0] cnt_r;

   // status depends on the count only
   assign ready_o = (cnt_r != full_cnt_lp);
   assign v_o     = (cnt_r != '0);
   assign data_o  = mem_r[rptr_r];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wptr_r <= '0;
         rptr_r <= '0;
         cnt_r  <= '0;
      end else begin
         if (v_i) begin
            wptr_r <= (wptr_r == last_ptr_lp) ? '0 : wptr_r + 1'b1;
         end
         if (yumi_i) begin
            rptr_r <= (rptr_r == last_ptr_lp) ? '0 : rptr_r + 1'b1;
         end
         case ({v_i, yumi_i})
            2'b10:   cnt_r <= cnt_r + 1'b1;
            2'b01:   cnt_r <= cnt_r - 1'b1;
            default: cnt_r <= cnt_r;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (v_i) begin
         mem_r[wptr_r] <= data_i;
      end
   end

   // callers must respect the ready-then-valid and yumi contracts
   push_when_full_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      v_i |-> ready_o);
   pop_when_empty_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      yumi_i |-> v_o);

endmodule

//--- hw/mc_tile.sv
/*
 Manycore network tile top. Endpoint and scratchpad core side by side.
 No routing is done. All incoming requests are taken as local.
 my_x_i and my_y_i must stay constant while out of reset.
*/
`timescale 1ns/1ps
`include "mc_tile_defines.svh"

module mc_tile
   import mc_packet_pkg::*, mc_link_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic [`MC_X_CORD_WIDTH-1:0] my_x_i,
   input  logic [`MC_Y_CORD_WIDTH-1:0] my_y_i,

   input  mc_link_sif_s                link_sif_i,
   output mc_link_sif_s                link_sif_o,

   input  logic                        cmd_v_i,
   input  mc_req_pkt_s                 cmd_i,
   output logic                        cmd_ready_o,

   output logic                        returned_v_o,
   output mc_rsp_pkt_s                 returned_o,
   input  logic                        returned_ready_i,
   output logic [`MC_CREDIT_WIDTH-1:0] out_credits_o
);

   // endpoint to core
   logic        req_v;
   mc_req_pkt_s req;
   logic        req_yumi;

   // core to endpoint
   logic        rsp_v;
   mc_rsp_pkt_s rsp;
   logic        rsp_ready;

   mc_endpoint endpoint (
      .clk_i, .arst_n_i, .my_x_i, .my_y_i,
      .link_sif_i, .link_sif_o,
      .cmd_v_i, .cmd_i, .cmd_ready_o,
      .returned_v_o, .returned_o, .returned_ready_i, .out_credits_o,
      .req_v_o(req_v), .req_o(req), .req_yumi_i(req_yumi),
      .rsp_v_i(rsp_v), .rsp_i(rsp), .rsp_ready_o(rsp_ready)
   );

   mc_tile_core core (
      .clk_i, .arst_n_i,
      .req_v_i(req_v), .req_i(req), .req_yumi_o(req_yumi),
      .rsp_v_o(rsp_v), .rsp_o(rsp), .rsp_ready_i(rsp_ready)
   );

endmodule

//--- hw/mc_tile_core.sv
/*
 Scratchpad tile behaviour. It serves loads and stores from a local memory.
 Only the low address bits index the memory. The upper bits are ignored.
 Memory contents are undefined after reset.
 One response is held at a time. It stalls request intake until taken.
*/
`timescale 1ns/1ps
`include "mc_tile_defines.svh"

module mc_tile_core
   import mc_packet_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_n_i,

   input  logic        req_v_i,
   input  mc_req_pkt_s req_i,
   output logic        req_yumi_o,

   output logic        rsp_v_o,
   output mc_rsp_pkt_s rsp_o,
   input  logic        rsp_ready_i
);

   localparam int idx_w_lp = $clog2(`MC_DMEM_WORDS);

   logic [`MC_DATA_WIDTH-1:0] dmem_r [`MC_DMEM_WORDS];
   logic [idx_w_lp-1:0]       idx;
   logic                      is_store;
   logic                      rsp_v_r;
   mc_rsp_pkt_s               rsp_r;
   logic                      rsp_taken;

   assign idx       = req_i.addr[idx_w_lp-1:0];
   assign is_store  = (req_i.op == MC_OP_STORE);
   assign rsp_taken = rsp_v_r & rsp_ready_i;

   // pop only when the response slot is free or frees up this cycle
   assign req_yumi_o = req_v_i & (~rsp_v_r | rsp_ready_i);

   assign rsp_v_o = rsp_v_r;
   assign rsp_o   = rsp_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_v_r <= 1'b0;
      end else if (req_yumi_o) begin
         rsp_v_r <= 1'b1;
      end else if (rsp_taken) begin
         rsp_v_r <= 1'b0;
      end
   end

   // memory access and response capture happen at the pop edge
   always_ff @(posedge clk_i) begin
      if (req_yumi_o) begin
         if (is_store) begin
            dmem_r[idx] <= req_i.data;
         end
         rsp_r.rsp_type <= is_store ? MC_RSP_STORE_ACK : MC_RSP_LOAD_DATA;
         rsp_r.data     <= is_store ? '0 : dmem_r[idx];
         rsp_r.reg_id   <= req_i.reg_id;
         // reply goes back to whoever asked
         rsp_r.dst_x    <= req_i.src_x;
         rsp_r.dst_y    <= req_i.src_y;
      end
   end

   // a held response stays put until the endpoint takes it
   rsp_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (rsp_v_r && !rsp_ready_i) |=> (rsp_v_r && $stable(rsp_r)));

endmodule

//--- mc_tile.f
+incdir+common
common/mc_packet_pkg.sv
common/mc_link_pkg.sv
hw/endpoint/mc_fifo.sv
hw/endpoint/mc_endpoint.sv
hw/mc_tile_core.sv
hw/mc_tile.sv
testbench/tb_mc_tile.sv

//--- testbench/tb_mc_tile.sv
/*
 Random network neighbour and command source around the tile.
 Loads only target indices that were stored to earlier, since memory is not reset.
 Every returned response answers one outgoing request, so credits stay in range.
*/
`timescale 1ns/1ps
`include "mc_tile_defines.svh"

module tb_mc_tile
   import mc_packet_pkg::*, mc_link_pkg::*;
();

   localparam int num_req_lp  = 60;
   localparam int num_cmd_lp  = 40;
   localparam int max_cred_lp = `MC_MAX_OUT_CREDITS;
   localparam int timeout_lp  = 40 * (num_req_lp + num_cmd_lp + max_cred_lp + 1);

   logic                        clk_i;
   logic                        arst_n_i;
   logic [`MC_X_CORD_WIDTH-1:0] my_x_i;
   logic [`MC_Y_CORD_WIDTH-1:0] my_y_i;
   mc_link_sif_s                link_sif_i;
   mc_link_sif_s                link_sif_o;
   logic                        cmd_v_i;
   mc_req_pkt_s                 cmd_i;
   logic                        cmd_ready_o;
   logic                        returned_v_o;
   mc_rsp_pkt_s                 returned_o;
   logic                        returned_ready_i;
   logic [`MC_CREDIT_WIDTH-1:0] out_credits_o;

   // reference model state
   logic [`MC_DATA_WIDTH-1:0] mem_model [256];
   bit                        written_flag [256];
   logic [7:0]                written_q [$];
   mc_rsp_pkt_s               exp_rsp [$];
   mc_req_pkt_s               exp_out [$];
   mc_rsp_pkt_s               net_ret [$];
   mc_rsp_pkt_s               exp_ret [$];
   int                        credits;
   int                        acc_cmds;

   integer seed = 78;
   int     cycle_cnt = 0;
   int     req_left;
   int     cmd_left;
   bit     running;
   bit     cmd_eager;
   bit     hold_returned;
   bit     release_one;
   bit     fwd_ready_on;
   bit     in_req_xfer;
   bit     cmd_xfer;
   bit     ret_in_xfer;

   mc_tile dut (
      .clk_i, .arst_n_i, .my_x_i, .my_y_i,
      .link_sif_i, .link_sif_o,
      .cmd_v_i, .cmd_i, .cmd_ready_o,
      .returned_v_o, .returned_o, .returned_ready_i, .out_credits_o
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_lp) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_lp);
         $display("Testbench failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   task automatic compare_values(input string name, input logic [127:0] exp_v,
                                 input logic [127:0] act_v);
      if (exp_v !== act_v) begin
         $display("** Error: %s expected %h actual %h", name, exp_v, act_v);
         $display("Testbench failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic make_request(output mc_req_pkt_s pkt);
      logic [7:0] idx;
      pkt.data   = $random(seed);
      pkt.reg_id = $random(seed);
      pkt.src_x  = $random(seed);
      pkt.src_y  = $random(seed);
      pkt.dst_x  = my_x_i;
      pkt.dst_y  = my_y_i;
      if (written_q.size() == 0 || ({$random(seed)} % 2) == 0) begin
         pkt.op = MC_OP_STORE;
         // half the stores overwrite an index that already holds data
         if (written_q.size() > 0 && ({$random(seed)} % 2) == 0) begin
            idx = written_q[{$random(seed)} % written_q.size()];
         end else begin
            idx = 8'($random(seed));
         end
      end else begin
         pkt.op = MC_OP_LOAD;
         idx    = written_q[{$random(seed)} % written_q.size()];
      end
      // upper address bits vary to show they are ignored
      pkt.addr = {8'($random(seed)), idx};
   endtask

   task automatic model_request(input mc_req_pkt_s pkt);
      mc_rsp_pkt_s r;
      logic [7:0]  idx;
      idx      = pkt.addr[7:0];
      r.reg_id = pkt.reg_id;
      r.dst_x  = pkt.src_x;
      r.dst_y  = pkt.src_y;
      if (pkt.op == MC_OP_STORE) begin
         r.rsp_type     = MC_RSP_STORE_ACK;
         r.data         = '0;
         mem_model[idx] = pkt.data;
         if (!written_flag[idx]) begin
            written_flag[idx] = 1'b1;
            written_q.push_back(idx);
         end
      end else begin
         r.rsp_type = MC_RSP_LOAD_DATA;
         r.data     = mem_model[idx];
      end
      exp_rsp.push_back(r);
   endtask

   task automatic drive_inputs();
      mc_req_pkt_s pkt;
      logic [95:0] bits;
      // a valid is only changed once the held packet has moved
      if (!link_sif_i.fwd.v || in_req_xfer) begin
         link_sif_i.fwd.v = 1'b0;
         if (req_left > 0 && ({$random(seed)} % 2) == 1) begin
            make_request(pkt);
            link_sif_i.fwd.v    = 1'b1;
            link_sif_i.fwd.data = pkt;
            req_left--;
         end
      end
      if (!cmd_v_i || cmd_xfer) begin
         cmd_v_i = 1'b0;
         if (cmd_left > 0 && (cmd_eager || ({$random(seed)} % 2) == 1)) begin
            bits    = {$random(seed), $random(seed), $random(seed)};
            cmd_i   = bits[$bits(mc_req_pkt_s)-1:0];
            cmd_v_i = 1'b1;
            cmd_left--;
         end
      end
      if (!link_sif_i.rev.v || ret_in_xfer) begin
         link_sif_i.rev.v = 1'b0;
         if (net_ret.size() > 0 && ({$random(seed)} % 2) == 1) begin
            link_sif_i.rev.v    = 1'b1;
            link_sif_i.rev.data = net_ret[0];
         end
      end
      link_sif_i.fwd.ready = fwd_ready_on ? 1'b1 : ({$random(seed)} % 3 != 0);
      link_sif_i.rev.ready = ({$random(seed)} % 3 != 0);
      returned_ready_i     = hold_returned ? release_one : ({$random(seed)} % 2 == 1);
   endtask

   task automatic sample_outputs();
      mc_rsp_pkt_s r;
      mc_req_pkt_s q;
      compare_values("credit count", credits, out_credits_o);
      in_req_xfer = link_sif_i.fwd.v && link_sif_o.fwd.ready;
      cmd_xfer    = cmd_v_i && cmd_ready_o;
      ret_in_xfer = link_sif_i.rev.v && link_sif_o.rev.ready;
      if (in_req_xfer) model_request(link_sif_i.fwd.data);
      if (link_sif_o.rev.v && link_sif_i.rev.ready) begin
         if (exp_rsp.size() == 0) stop_with_error("response sent with no request pending");
         else begin
            r = exp_rsp.pop_front();
            compare_values("store/load response", r, link_sif_o.rev.data);
         end
      end
      if (link_sif_o.fwd.v && link_sif_i.fwd.ready) begin
         if (exp_out.size() == 0) stop_with_error("outgoing request with no command accepted");
         else begin
            q = exp_out.pop_front();
            compare_values("outgoing request", q, link_sif_o.fwd.data);
            // the network answers each request later
            r.rsp_type = mc_rsp_type_e'($random(seed));
            r.data     = $random(seed);
            r.reg_id   = q.reg_id;
            r.dst_x    = my_x_i;
            r.dst_y    = my_y_i;
            net_ret.push_back(r);
         end
      end
      if (cmd_xfer) begin
         q       = cmd_i;
         q.src_x = my_x_i;
         q.src_y = my_y_i;
         exp_out.push_back(q);
         credits--;
         acc_cmds++;
      end
      if (ret_in_xfer) begin
         exp_ret.push_back(link_sif_i.rev.data);
         void'(net_ret.pop_front());
      end
      if (returned_v_o && returned_ready_i) begin
         if (exp_ret.size() == 0) stop_with_error("returned response that never arrived");
         else begin
            r = exp_ret.pop_front();
            compare_values("returned response", r, returned_o);
            credits++;
            release_one = 1'b0;
         end
      end
   endtask

   always begin
      @(negedge clk_i);
      if (running) begin
         drive_inputs();
         #5;
         sample_outputs();
      end
   end

   task automatic wait_until_drained();
      while (req_left > 0 || cmd_left > 0 || link_sif_i.fwd.v || cmd_v_i ||
             exp_rsp.size() > 0 || exp_out.size() > 0 || net_ret.size() > 0 ||
             exp_ret.size() > 0 || credits != max_cred_lp) begin
         @(posedge clk_i);
      end
   endtask

   initial begin
      arst_n_i         = 1'b0;
      my_x_i           = 4'd5;
      my_y_i           = 3'd2;
      link_sif_i       = '0;
      cmd_v_i          = 1'b0;
      cmd_i            = '0;
      returned_ready_i = 1'b0;
      credits          = max_cred_lp;
      acc_cmds         = 0;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      #5;
      compare_values("reset fwd valid", 0, link_sif_o.fwd.v);
      compare_values("reset rev valid", 0, link_sif_o.rev.v);
      compare_values("reset returned valid", 0, returned_v_o);
      compare_values("reset credits", max_cred_lp, out_credits_o);
      compare_values("reset fwd ready", 1, link_sif_o.fwd.ready);
      compare_values("reset rev ready", 1, link_sif_o.rev.ready);

      // random traffic in both directions
      req_left = num_req_lp;
      cmd_left = num_cmd_lp;
      running  = 1'b1;
      wait_until_drained();

      // use up all credits, then free exactly one
      fwd_ready_on  = 1'b1;
      hold_returned = 1'b1;
      cmd_eager     = 1'b1;
      cmd_left      = max_cred_lp + 1;
      while (credits != 0) @(negedge clk_i);
      repeat (4) begin
         @(negedge clk_i);
         #6;
         compare_values("cmd ready at zero credits", 0, cmd_ready_o);
      end
      release_one = 1'b1;
      while (acc_cmds != num_cmd_lp + max_cred_lp + 1) @(posedge clk_i);
      hold_returned = 1'b0;
      cmd_eager     = 1'b0;
      fwd_ready_on  = 1'b0;
      wait_until_drained();

      $display("Testbench passed");
      $finish;
   end

endmodule
